// File: flist.f
source/obi_pkg.sv
source/clock_gate_cell.sv
source/sram_bank.sv
source/bank_decoder.sv
source/memory_subsystem.sv
source/mem_subsys_top.sv
verification/mem_subsys_properties.sv
verification/tb_mem_subsys.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the SRAM subsystem testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_mem_subsys -f flist.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

// File: verification/tb_mem_subsys.sv
// =========================================================================
// Testbench for the banked SRAM subsystem: table-driven directed steps
// followed by pipelined random traffic against a reference memory
// =========================================================================
`timescale 1ns/1ps

module tb_mem_subsys;
  import obi_pkg::*;

  localparam int unsigned TIMEOUT = 64;
  localparam int unsigned HOLD_CYCLES = 8;
  localparam int unsigned NUM_RANDOM = 48;
  localparam int unsigned NUM_STEPS = 39;

  localparam logic [2:0] OP_WR = 3'd0;
  localparam logic [2:0] OP_RD = 3'd1;
  localparam logic [2:0] OP_OFF = 3'd2;
  localparam logic [2:0] OP_ON = 3'd3;
  localparam logic [2:0] OP_CLK = 3'd4;
  localparam logic [2:0] OP_HOLD = 3'd5;
  localparam logic [2:0] OP_DONE = 3'd6;

  // power and clock steps pick the bank from address bits 11:10
  typedef struct packed {
    logic [2:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    logic        ret;
    logic [31:0] exp;
  } step_t;

  logic                 clk_cg = 1'b0;
  logic                 rst_ni;
  logic [NUM_BANKS-1:0] bank_clk_en;
  logic [NUM_BANKS-1:0] pwrgate_n;
  logic [NUM_BANKS-1:0] set_retentive_n;
  logic [NUM_BANKS-1:0] pwrgate_ack_n;
  obi_req_t             obi_req;
  obi_resp_t            obi_resp;
  logic [31:0]          ref_mem [1024];
  logic [31:0]          lfsr;
  int unsigned          errors;
  int unsigned          checks;

  step_t steps [NUM_STEPS] = '{
    '{OP_WR,   32'h0000_0010, 32'h1111_1111, 4'hf, 1'b0, 32'h0},
    '{OP_WR,   32'h0000_0414, 32'h2222_2222, 4'hf, 1'b0, 32'h0},
    '{OP_WR,   32'h0000_0818, 32'h3333_3333, 4'hf, 1'b0, 32'h0},
    '{OP_WR,   32'h0000_0c1c, 32'h4444_4444, 4'hf, 1'b0, 32'h0},
    '{OP_RD,   32'h0000_0010, 32'h0,         4'hf, 1'b0, 32'h1111_1111},
    '{OP_RD,   32'h0000_0414, 32'h0,         4'hf, 1'b0, 32'h2222_2222},
    '{OP_RD,   32'h0000_0818, 32'h0,         4'hf, 1'b0, 32'h3333_3333},
    '{OP_RD,   32'h0000_0c1c, 32'h0,         4'hf, 1'b0, 32'h4444_4444},
    '{OP_WR,   32'h0000_0020, 32'haabb_ccdd, 4'hf, 1'b0, 32'h0},
    '{OP_WR,   32'h0000_0020, 32'h1122_3344, 4'h5, 1'b0, 32'h0},
    '{OP_RD,   32'h0000_0020, 32'h0,         4'hf, 1'b0, 32'haa22_cc44},
    '{OP_WR,   32'h0000_0024, 32'h0000_ee00, 4'h2, 1'b0, 32'h0},
    '{OP_RD,   32'h0000_0024, 32'h0,         4'hf, 1'b0, 32'h0000_ee00},
    '{OP_WR,   32'h0000_0030, 32'ha0a0_a0a0, 4'hf, 1'b0, 32'h0},
    '{OP_WR,   32'h0000_0430, 32'hb1b1_b1b1, 4'hf, 1'b0, 32'h0},
    '{OP_WR,   32'h0000_0830, 32'hc2c2_c2c2, 4'hf, 1'b0, 32'h0},
    '{OP_WR,   32'h0000_0c30, 32'hd3d3_d3d3, 4'hf, 1'b0, 32'h0},
    '{OP_RD,   32'h0000_0030, 32'h0,         4'hf, 1'b0, 32'ha0a0_a0a0},
    '{OP_RD,   32'h0000_0830, 32'h0,         4'hf, 1'b0, 32'hc2c2_c2c2},
    '{OP_WR,   32'hffff_f434, 32'h5a5a_5a5a, 4'hf, 1'b0, 32'h0},
    '{OP_RD,   32'h0000_0434, 32'h0,         4'hf, 1'b0, 32'h5a5a_5a5a},
    '{OP_RD,   32'h1234_5c30, 32'h0,         4'hf, 1'b0, 32'hd3d3_d3d3},
    '{OP_OFF,  32'h0000_0800, 32'h0,         4'h0, 1'b1, 32'h0},
    '{OP_HOLD, 32'h0000_0818, 32'h0,         4'h0, 1'b0, 32'h0},
    '{OP_ON,   32'h0000_0800, 32'h0,         4'h0, 1'b1, 32'h0},
    '{OP_DONE, 32'h0,         32'h0,         4'h0, 1'b0, 32'h3333_3333},
    '{OP_RD,   32'h0000_0830, 32'h0,         4'hf, 1'b0, 32'hc2c2_c2c2},
    '{OP_OFF,  32'h0000_0400, 32'h0,         4'h0, 1'b0, 32'h0},
    '{OP_ON,   32'h0000_0400, 32'h0,         4'h0, 1'b0, 32'h0},
    '{OP_RD,   32'h0000_0414, 32'h0,         4'hf, 1'b0, 32'h0},
    '{OP_RD,   32'h0000_0434, 32'h0,         4'hf, 1'b0, 32'h0},
    '{OP_RD,   32'h0000_0010, 32'h0,         4'hf, 1'b0, 32'h1111_1111},
    '{OP_RD,   32'h0000_0c1c, 32'h0,         4'hf, 1'b0, 32'h4444_4444},
    '{OP_WR,   32'h0000_0414, 32'h0000_beef, 4'h3, 1'b0, 32'h0},
    '{OP_RD,   32'h0000_0414, 32'h0,         4'hf, 1'b0, 32'h0000_beef},
    '{OP_CLK,  32'h0000_0c00, 32'h0,         4'h0, 1'b0, 32'h0},
    '{OP_HOLD, 32'h0000_0c30, 32'h0,         4'h0, 1'b0, 32'h0},
    '{OP_CLK,  32'h0000_0c00, 32'h1,         4'h0, 1'b0, 32'h0},
    '{OP_DONE, 32'h0,         32'h0,         4'h0, 1'b0, 32'hd3d3_d3d3}
  };

  mem_subsys_top dut (
    .clk_cg           (clk_cg),
    .rst_ni           (rst_ni),
    .bank_clk_en_i    (bank_clk_en),
    .obi_req_i        (obi_req),
    .obi_resp_o       (obi_resp),
    .pwrgate_ni       (pwrgate_n),
    .set_retentive_ni (set_retentive_n),
    .pwrgate_ack_no   (pwrgate_ack_n)
  );

  always #4 clk_cg = ~clk_cg;

  // x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // word index is byte address bits 11:2, bank select included
  task automatic ref_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        ref_mem[addr[11:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
  endtask

  // called at a falling edge, where gnt is stable
  task automatic wait_gnt();
    int unsigned n;
    n = 0;
    while (!obi_resp.gnt && n < TIMEOUT) begin
      @(negedge clk_cg);
      n++;
    end
    if (!obi_resp.gnt) begin
      report_timeout("gnt");
    end
  endtask

  task automatic check_response(input logic is_read, input logic [31:0] exp);
    check_value("obi_resp_o.rvalid", 32'(obi_resp.rvalid), 32'h1);
    if (is_read) begin
      check_value("obi_resp_o.rdata", obi_resp.rdata, exp);
    end
  endtask

  task automatic finish_access(input logic is_read, input logic [31:0] exp);
    @(posedge clk_cg);
    obi_req.req <= 1'b0;
    @(negedge clk_cg);
    check_response(is_read, exp);
  endtask

  task automatic single_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] data, input logic [3:0] be,
                               input logic [31:0] exp);
    @(posedge clk_cg);
    obi_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: data};
    @(negedge clk_cg);
    wait_gnt();
    finish_access(!we, exp);
  endtask

  task automatic hold_check();
    for (int c = 0; c < HOLD_CYCLES; c++) begin
      @(negedge clk_cg);
      checks++;
      if (obi_resp.gnt) begin
        errors++;
        $display("gnt was given by a bank that is powered down or has no clock");
      end
    end
  endtask

  task automatic power_step(input logic [1:0] bank, input logic level, input logic ret);
    int unsigned n;
    @(posedge clk_cg);
    pwrgate_n[bank] <= level;
    set_retentive_n[bank] <= !ret;
    n = 0;
    // n counts the rising edges after the one that changed the request
    @(negedge clk_cg);
    while (pwrgate_ack_n[bank] !== level && n < TIMEOUT) begin
      @(negedge clk_cg);
      n++;
    end
    if (pwrgate_ack_n[bank] !== level) begin
      report_timeout("power acknowledge");
    end else begin
      check_value("pwrgate_ack_no delay", n, PWR_ACK_DELAY);
    end
  endtask

  task automatic apply_step(input step_t s);
    logic [1:0] bank;
    bank = s.addr[11:10];
    case (s.op)
      OP_WR: begin
        single_access(1'b1, s.addr, s.data, s.be, 32'h0);
        ref_write(s.addr, s.data, s.be);
      end
      OP_RD: single_access(1'b0, s.addr, 32'h0, 4'hf, s.exp);
      OP_OFF: begin
        power_step(bank, 1'b0, s.ret);
        if (!s.ret) begin
          for (int w = 0; w < BANK_WORDS; w++) begin
            ref_mem[{bank, w[7:0]}] = '0;
          end
        end
      end
      OP_ON: power_step(bank, 1'b1, s.ret);
      OP_CLK: begin
        @(posedge clk_cg);
        bank_clk_en[bank] <= s.data[0];
        @(negedge clk_cg);
      end
      OP_HOLD: begin
        @(posedge clk_cg);
        obi_req <= '{req: 1'b1, we: 1'b0, be: 4'hf, addr: s.addr, wdata: 32'h0};
        hold_check();
      end
      default: begin
        wait_gnt();
        finish_access(1'b1, s.exp);
      end
    endcase
  endtask

  // each new request goes out on the edge that accepts the previous one
  task automatic random_traffic();
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    logic        we;
    logic        pend;
    logic        pend_rd;
    logic [31:0] pend_exp;
    pend = 1'b0;
    pend_rd = 1'b0;
    pend_exp = '0;
    @(posedge clk_cg);
    for (int k = 0; k < NUM_RANDOM; k++) begin
      addr = (rand_bits(20) << 12) | (rand_bits(2) << 10) | (rand_bits(4) << 2);
      we = rand_bits(1) != 0;
      data = rand_bits(32);
      be = 4'(rand_bits(4));
      obi_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: data};
      @(negedge clk_cg);
      if (pend) begin
        check_response(pend_rd, pend_exp);
      end
      wait_gnt();
      @(posedge clk_cg);
      pend = 1'b1;
      pend_rd = !we;
      pend_exp = ref_mem[addr[11:2]];
      if (we) begin
        ref_write(addr, data, be);
      end
    end
    obi_req.req <= 1'b0;
    @(negedge clk_cg);
    check_response(pend_rd, pend_exp);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    lfsr = 32'h867c3ad5;
    rst_ni = 1'b0;
    obi_req = '0;
    bank_clk_en = '1;
    pwrgate_n = '1;
    set_retentive_n = '1;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = '0;
    end
    repeat (10) @(posedge clk_cg);
    rst_ni <= 1'b1;
    @(negedge clk_cg);
    check_value("pwrgate_ack_no", 32'(pwrgate_ack_n), 32'hf);
    for (int i = 0; i < NUM_STEPS; i++) begin
      apply_step(steps[i]);
    end
    random_traffic();
    repeat (4) @(posedge clk_cg);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verification/mem_subsys_properties.sv
// =========================================================================
// Bus protocol and power handshake assertions for the SRAM subsystem top
// =========================================================================
`timescale 1ns/1ps

module mem_subsys_properties (
  input logic                          clk_cg,
  input logic                          rst_ni,
  input obi_pkg::obi_req_t             obi_req_i,
  input obi_pkg::obi_resp_t            obi_resp_o,
  input logic [obi_pkg::NUM_BANKS-1:0] pwrgate_ni,
  input logic [obi_pkg::NUM_BANKS-1:0] pwrgate_ack_no
);
  import obi_pkg::*;

  logic accepted;

  assign accepted = obi_req_i.req && obi_resp_o.gnt;

  rvalid_after_accept: assert property (@(posedge clk_cg) disable iff (!rst_ni)
    accepted |=> obi_resp_o.rvalid) else $error("rvalid missing after an acceptance");

  rvalid_only_after_accept: assert property (@(posedge clk_cg) disable iff (!rst_ni)
    obi_resp_o.rvalid |-> $past(accepted)) else $error("rvalid without an acceptance");

  gnt_needs_req: assert property (@(posedge clk_cg) disable iff (!rst_ni)
    obi_resp_o.gnt |-> obi_req_i.req) else $error("gnt without req");

  reset_values: assert property (@(posedge clk_cg)
    !rst_ni |=> !obi_resp_o.gnt && !obi_resp_o.rvalid && pwrgate_ack_no == '1)
    else $error("outputs not inactive after reset");

  // the acknowledge is the request delayed by a fixed number of cycles
  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_ack
    ack_follows_req: assert property (@(posedge clk_cg) disable iff (!rst_ni)
      pwrgate_ack_no[i] == $past(pwrgate_ni[i], PWR_ACK_DELAY))
      else $error("power acknowledge does not follow its request");
  end

endmodule

bind mem_subsys_top mem_subsys_properties u_props (.*);

// File: source/mem_subsys_top.sv
// =========================================================================
// Banked SRAM subsystem top: bank decoder in front of the memory banks
// =========================================================================
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                          clk_cg,
  input  logic                          rst_ni,
  input  logic [obi_pkg::NUM_BANKS-1:0] bank_clk_en_i,
  input  obi_pkg::obi_req_t             obi_req_i,
  output obi_pkg::obi_resp_t            obi_resp_o,
  input  logic [obi_pkg::NUM_BANKS-1:0] pwrgate_ni,
  input  logic [obi_pkg::NUM_BANKS-1:0] set_retentive_ni,
  output logic [obi_pkg::NUM_BANKS-1:0] pwrgate_ack_no
);
  import obi_pkg::*;

  obi_req_t  [NUM_BANKS-1:0] bank_req;
  obi_resp_t [NUM_BANKS-1:0] bank_resp;

  bank_decoder u_decoder (
    .clk_cg      (clk_cg),
    .rst_ni      (rst_ni),
    .obi_req_i   (obi_req_i),
    .obi_resp_o  (obi_resp_o),
    .bank_req_o  (bank_req),
    .bank_resp_i (bank_resp)
  );

  memory_subsystem u_mem_subsys (
    .clk_cg           (clk_cg),
    .rst_ni           (rst_ni),
    .bank_clk_en_i    (bank_clk_en_i),
    .bank_req_i       (bank_req),
    .bank_resp_o      (bank_resp),
    .pwrgate_ni       (pwrgate_ni),
    .set_retentive_ni (set_retentive_ni),
    .pwrgate_ack_no   (pwrgate_ack_no)
  );

endmodule

// File: source/memory_subsystem.sv
// =========================================================================
// Memory subsystem: per-bank clock gates and SRAM banks, with grant
// masking and rvalid generation for each bank port
// =========================================================================
`timescale 1ns/1ps

module memory_subsystem (
  input  logic                                        clk_cg,
  input  logic                                        rst_ni,
  input  logic [obi_pkg::NUM_BANKS-1:0]               bank_clk_en_i,
  input  obi_pkg::obi_req_t [obi_pkg::NUM_BANKS-1:0]  bank_req_i,
  output obi_pkg::obi_resp_t [obi_pkg::NUM_BANKS-1:0] bank_resp_o,
  input  logic [obi_pkg::NUM_BANKS-1:0]               pwrgate_ni,
  input  logic [obi_pkg::NUM_BANKS-1:0]               set_retentive_ni,
  output logic [obi_pkg::NUM_BANKS-1:0]               pwrgate_ack_no
);
  import obi_pkg::*;

  logic [NUM_BANKS-1:0] bank_clk;
  logic [NUM_BANKS-1:0] bank_ready;
  logic [NUM_BANKS-1:0] gnt;
  logic [NUM_BANKS-1:0] rvalid_q;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    logic [WORD_IDX_W-1:0] word_idx;
    logic [DATA_W-1:0]     rdata;

    assign word_idx = bank_req_i[i].addr[WORD_IDX_LSB +: WORD_IDX_W];

    // a bank with its clock stopped would never see the access edge
    assign gnt[i] = bank_req_i[i].req && bank_ready[i] && bank_clk_en_i[i];

    clock_gate_cell u_clk_gate (
      .clk_i (clk_cg),
      .en_i  (bank_clk_en_i[i]),
      .clk_o (bank_clk[i])
    );

    sram_bank u_sram (
      .clk_i            (bank_clk[i]),
      .rst_ni           (rst_ni),
      .req_i            (bank_req_i[i].req),
      .we_i             (bank_req_i[i].we),
      .addr_i           (word_idx),
      .wdata_i          (bank_req_i[i].wdata),
      .be_i             (bank_req_i[i].be),
      .pwrgate_ni       (pwrgate_ni[i]),
      .set_retentive_ni (set_retentive_ni[i]),
      .rdata_o          (rdata),
      .pwrgate_ack_no   (pwrgate_ack_no[i]),
      .ready_o          (bank_ready[i])
    );

    assign bank_resp_o[i] = '{gnt: gnt[i], rvalid: rvalid_q[i], rdata: rdata};
  end

  // rvalid runs on the free clock so it always drops after one cycle
  always_ff @(posedge clk_cg) begin
    if (!rst_ni) begin
      rvalid_q <= '0;
    end else begin
      rvalid_q <= gnt;
    end
  end

endmodule

// File: source/bank_decoder.sv
// =========================================================================
// Bank decoder: routes the bus request to one bank by address and steers
// the response back from the bank of the outstanding access
// =========================================================================
`timescale 1ns/1ps

module bank_decoder (
  input  logic                                        clk_cg,
  input  logic                                        rst_ni,
  input  obi_pkg::obi_req_t                           obi_req_i,
  output obi_pkg::obi_resp_t                          obi_resp_o,
  output obi_pkg::obi_req_t [obi_pkg::NUM_BANKS-1:0]  bank_req_o,
  input  obi_pkg::obi_resp_t [obi_pkg::NUM_BANKS-1:0] bank_resp_i
);
  import obi_pkg::*;

  bank_sel_t sel;
  bank_sel_t rsp_sel_q;
  logic      rsp_pend_q;
  logic      accept;

  // bits above the bank select are not decoded, so addresses alias
  assign sel = obi_req_i.addr[BANK_SEL_LSB +: BANK_SEL_W];

  assign accept = obi_req_i.req && bank_resp_i[sel].gnt;

  // payload goes to every bank, only the selected one sees req
  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      bank_req_o[i] = obi_req_i;
      bank_req_o[i].req = obi_req_i.req && (sel == bank_sel_t'(i));
    end
  end

  // remembers which bank answers next, so the following request can
  // target another bank in the same cycle the response comes back
  always_ff @(posedge clk_cg) begin
    if (!rst_ni) begin
      rsp_pend_q <= 1'b0;
      rsp_sel_q  <= '0;
    end else begin
      rsp_pend_q <= accept;
      if (accept) begin
        rsp_sel_q <= sel;
      end
    end
  end

  assign obi_resp_o.gnt    = bank_resp_i[sel].gnt;
  assign obi_resp_o.rvalid = rsp_pend_q && bank_resp_i[rsp_sel_q].rvalid;
  assign obi_resp_o.rdata  = bank_resp_i[rsp_sel_q].rdata;

endmodule

// File: source/sram_bank.sv
// =========================================================================
// Behavioural SRAM bank with byte-enable writes, per-word valid bits and
// a power-gate sequencer that supports retention
// =========================================================================
`timescale 1ns/1ps

module sram_bank (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [obi_pkg::WORD_IDX_W-1:0] addr_i,
  input  logic [obi_pkg::DATA_W-1:0]     wdata_i,
  input  logic [obi_pkg::BE_W-1:0]       be_i,
  input  logic                           pwrgate_ni,
  input  logic                           set_retentive_ni,
  output logic [obi_pkg::DATA_W-1:0]     rdata_o,
  output logic                           pwrgate_ack_no,
  output logic                           ready_o
);
  import obi_pkg::*;

  localparam int unsigned CNT_W = $clog2(PWR_ACK_DELAY + 1);

  logic [DATA_W-1:0]     mem_q [BANK_WORDS];
  logic [BANK_WORDS-1:0] valid_q;
  logic [DATA_W-1:0]     old_word;
  logic [DATA_W-1:0]     wr_word;
  logic [DATA_W-1:0]     rdata_q;
  logic [CNT_W-1:0]      cnt_q;
  logic                  ack_q;
  logic                  pwr_pending;
  logic                  pwr_off_req;
  logic                  access;

  // request and acknowledge differ for the whole transition
  assign pwr_pending = pwrgate_ni != ack_q;

  // first cycle of a power-off request, where retention is sampled
  assign pwr_off_req = pwr_pending && !pwrgate_ni && (cnt_q == '0);

  assign ready_o = pwrgate_ni && ack_q;
  assign access = req_i && ready_o;
  assign pwrgate_ack_no = ack_q;
  assign rdata_o = rdata_q;

  // an invalid word reads as zero, also for the bytes a partial write keeps
  assign old_word = valid_q[addr_i] ? mem_q[addr_i] : '0;

  always_comb begin
    for (int b = 0; b < BE_W; b++) begin
      wr_word[8*b +: 8] = be_i[b] ? wdata_i[8*b +: 8] : old_word[8*b +: 8];
    end
  end

  // the acknowledge takes the requested level PWR_ACK_DELAY cycles after
  // the request changed
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_q <= 1'b1;
      cnt_q <= '0;
    end else if (!pwr_pending) begin
      cnt_q <= '0;
    end else if (cnt_q == CNT_W'(PWR_ACK_DELAY - 1)) begin
      ack_q <= pwrgate_ni;
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (pwr_off_req && set_retentive_ni) begin
      // contents are lost without retention
      valid_q <= '0;
    end else if (access && we_i) begin
      valid_q[addr_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (we_i) begin
        mem_q[addr_i] <= wr_word;
      end else begin
        rdata_q <= old_word;
      end
    end
  end

endmodule

// File: source/clock_gate_cell.sv
// =========================================================================
// Latch-based clock gate, enable captured while the clock is low
// =========================================================================
`timescale 1ns/1ps

module clock_gate_cell (
  input  logic clk_i,
  input  logic en_i,
  output logic clk_o
);

  logic en_latch;

  // transparent only in the low phase, so the enable cannot change
  // while the gated clock is high
  always_latch begin
    if (!clk_i) begin
      en_latch = en_i;
    end
  end

  assign clk_o = clk_i & en_latch;

endmodule

// File: source/obi_pkg.sv
// =========================================================================
// OBI bus types and banked SRAM geometry for the on-chip memory subsystem
// =========================================================================
package obi_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W = DATA_W / 8;

  // memory geometry, one word-wide bank per select value
  localparam int unsigned NUM_BANKS = 4;
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned WORD_IDX_W = 8;
  localparam int unsigned WORD_IDX_LSB = 2;
  localparam int unsigned BANK_SEL_W = 2;
  localparam int unsigned BANK_SEL_LSB = WORD_IDX_LSB + WORD_IDX_W;

  // bank clock cycles from a power-gate request edge to its acknowledge
  localparam int unsigned PWR_ACK_DELAY = 4;

  typedef logic [BANK_SEL_W-1:0] bank_sel_t;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  // rdata only carries meaning together with rvalid of a read
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } obi_resp_t;

endpackage
